/* arm810.f */
uarch.sv
core_if.sv
core_fetch.sv
core_decode.sv
core_control.sv
core_regs.sv
core_alu.sv
core_shifter.sv
core_bus_arbiter.sv
arm810.sv
arm810_checker.sv
arm810_tb.sv

/* arm810.sv */
`default_nettype none

module arm810 (
	input  logic clk,
	input  logic rst,
	input  logic halt,

	output core_uarch::ptr bus_addr,
	output logic bus_start,
	output logic bus_write,
	input  logic bus_ready,
	input  core_uarch::word bus_data_rd,
	output core_uarch::word bus_data_wr,
	output logic halted
);

	// ##############################
	// Fetch and decode.
	// ##############################

	core_mem_if insn_mem();
	core_mem_if data_mem();
	core_dec_if dec();

	logic insn_valid, insn_pop, flush;
	core_uarch::word insn;
	core_uarch::ptr insn_pc, target;

	core_fetch #(.PREFETCH_ORDER(1)) fetch (
		.mem(insn_mem.requester),
		.*
	);

	core_decode decode (
		.insn(insn),
		.dec(dec.source)
	);

	// ##############################
	// Execute.
	// ##############################

	core_uarch::reg_num ra, rb, wr_r;
	core_uarch::word rd_value_a, rd_value_b, wr_value, pc_visible;
	logic wr_enable;

	core_uarch::alu_op alu_ctrl;
	core_uarch::word alu_a, alu_b, q_alu;
	core_uarch::psr_flags alu_flags;
	logic alu_write;

	core_uarch::word sh_base, q_shifter;
	core_uarch::shift_type sh_type;
	logic [4:0] sh_amount;
	logic c_shifter, flags_c;

	assign pc_visible = {insn_pc + 30'd2, 2'b00}; // r15 reads as the head pc plus 8.

	core_control control (
		.dec(dec.sink),
		.mem(data_mem.requester),
		.*
	);

	core_regs regs (
		.rd_r_a(ra),
		.rd_r_b(rb),
		.*
	);

	core_alu #(.W(32)) alu (
		.op(alu_ctrl),
		.a(alu_a),
		.b(alu_b),
		.c_in(flags_c),
		.q(q_alu),
		.nzcv(alu_flags),
		.write(alu_write)
	);

	core_shifter #(.W(32)) shifter (
		.base(sh_base),
		.sh_type(sh_type),
		.amount(sh_amount),
		.c_in(flags_c),
		.q(q_shifter),
		.c(c_shifter)
	);

	core_bus_arbiter arbiter (
		.insn_port(insn_mem.server),
		.data_port(data_mem.server),
		.*
	);

endmodule

`default_nettype wire

/* arm810_checker.sv */
`default_nettype none

module arm810_checker (
	input logic clk,
	input logic rst,
	input logic halt,
	input logic halted,
	input logic bus_start,
	input logic bus_write,
	input logic bus_ready
);

	logic outstanding;
	int unsigned failures = 0;

	always_ff @(posedge clk) begin
		if (rst)
			outstanding <= 1'b0;
		else if (bus_start)
			outstanding <= 1'b1;
		else if (bus_ready)
			outstanding <= 1'b0;
	end

	// ##############################
	// Bus and halt properties.
	// ##############################

	reset_quiet: assert property (@(posedge clk) rst |=> !bus_start)
		else begin
			$error("bus_start high during or just after reset");
			failures++;
		end

	one_in_flight: assert property (@(posedge clk) disable iff (rst) bus_start |-> !outstanding)
		else begin
			$error("bus_start while a transaction is outstanding");
			failures++;
		end

	no_write_halted: assert property (@(posedge clk) disable iff (rst)
		bus_start && bus_write |-> !halted)
		else begin
			$error("write started while halted");
			failures++;
		end

	// halted follows halt by one edge.
	halted_needs_halt: assert property (@(posedge clk) disable iff (rst) halted |-> $past(halt))
		else begin
			$error("halted high without halt");
			failures++;
		end

endmodule

bind arm810 arm810_checker bus_checks (
	.clk(clk),
	.rst(rst),
	.halt(halt),
	.halted(halted),
	.bus_start(bus_start),
	.bus_write(bus_write),
	.bus_ready(bus_ready)
);

`default_nettype wire

/* arm810_tb.sv */
`default_nettype none

module tb_clock (
	output logic clk
);
	initial clk = 1'b0;
	always #50 clk = ~clk;
endmodule

module arm810_tb;

	localparam int MEM_WORDS = 1024;
	localparam int RANDOM_WORDS = 150;
	localparam int SCRATCH = 768; // word index of the scratch area.
	localparam int RESULTS = 896;

	logic clk, rst, halt, bus_start, bus_write, bus_ready, halted;
	core_uarch::ptr bus_addr;
	core_uarch::word bus_data_rd, bus_data_wr;

	core_uarch::word mem[MEM_WORDS];
	core_uarch::word ref_mem[MEM_WORDS];
	core_uarch::word model_r[15];
	core_uarch::ptr exp_addr[$];
	core_uarch::word exp_data[$];
	logic [31:0] rng = 32'hcf40;
	logic n, z, c, v;
	logic [9:0] req_addr;
	int prog_len, exp_count, seen, wait_left, mismatches, other_errors;

	tb_clock clock (.clk(clk));

	arm810 u_arm810 (.*);

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic core_uarch::word ror32(core_uarch::word x, int amt);
		return amt == 0 ? x : (x >> amt) | (x << (32 - amt));
	endfunction

	// ##############################
	// Program generator.
	// ##############################

	function automatic core_uarch::word pc_rel(logic [3:0] rd, bit load, int pc, int slot);
		return {4'he, 3'b010, 4'b1100, load, 4'hf, rd, 12'(slot * 4 - pc * 4 - 8)};
	endfunction

	function automatic core_uarch::word random_dp();
		logic [3:0] op;
		logic [4:0] amt;
		logic [11:0] operand;
		logic imm, s;
		op = 4'(next_rand());
		imm = next_rand() % 2 == 1;
		s = op[3:2] == 2'b10 || next_rand() % 2 == 1; // compares always set flags.
		amt = next_rand() % 4 == 0 ? 5'd0 : 5'(next_rand()); // zero gives rrx and shifts by 32.
		if (imm)
			operand = 12'(next_rand());
		else
			operand = {amt, 2'(next_rand()), 1'b0, 4'(next_rand() % 15)};
		return {4'(next_rand() % 15), 2'b00, imm, op, s, 4'(next_rand() % 15),
			4'(next_rand() % 15), operand};
	endfunction

	task automatic build_program();
		int pc, slot, pick;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (i + 1) * 32'h9e3779b1;
		for (int i = 0; i < 15; i++)
			mem[i] = {4'he, 3'b001, 4'hd, 1'b0, 4'h0, 4'(i), 12'(next_rand())};
		pc = 15;
		while (pc < 15 + RANDOM_WORDS) begin
			pick = next_rand() % 16;
			if (pick < 11) begin
				mem[pc] = random_dp();
				pc++;
			end else if (pick < 13) begin
				mem[pc] = {4'(next_rand() % 15), 3'b101, 1'(pick - 11), 24'(next_rand() % 3)};
				pc++;
			end else begin
				slot = SCRATCH + next_rand() % 16;
				mem[pc] = pc_rel(4'(next_rand() % 15), 1'b0, pc, slot);
				mem[pc + 1] = pc_rel(4'(next_rand() % 15), 1'b1, pc + 1, slot);
				pc += 2;
			end
		end
		for (int i = 0; i < 15; i++)
			mem[pc + i] = pc_rel(4'(i), 1'b0, pc + i, RESULTS + i);
		mem[pc + 15] = {4'he, 3'b101, 1'b0, 24'hfffffe}; // branch to itself.
		prog_len = pc + 16;
		ref_mem = mem;
	endtask

	// ##############################
	// Reference model.
	// ##############################

	function automatic bit cond_pass(logic [3:0] cond);
		bit r;
		case (cond[3:1])
			3'd0: r = z;
			3'd1: r = c;
			3'd2: r = n;
			3'd3: r = v;
			3'd4: r = c && !z;
			3'd5: r = n == v;
			3'd6: r = !z && n == v;
			default: return 1'b1;
		endcase
		return r ^ cond[0]; // odd codes are the inverse of the even ones.
	endfunction

	task automatic shift_operand(input core_uarch::word x, input logic [1:0] kind,
		input logic [4:0] amt, output core_uarch::word q, output logic cout);
		logic signed [31:0] sx;
		sx = x;
		cout = c;
		case (kind)
			2'd0: begin
				q = x << amt;
				if (amt != 0)
					cout = x[32 - amt];
			end
			2'd1: begin
				q = amt == 0 ? 32'd0 : x >> amt;
				cout = amt == 0 ? x[31] : x[amt - 1];
			end
			2'd2: begin
				if (amt == 0) begin
					q = {32{x[31]}};
					cout = x[31];
				end else begin
					q = sx >>> amt;
					cout = x[amt - 1];
				end
			end
			default: begin
				q = amt == 0 ? {c, x[31:1]} : ror32(x, amt);
				cout = amt == 0 ? x[0] : q[31];
			end
		endcase
	endtask

	task automatic add_with_carry(input core_uarch::word x, input core_uarch::word y,
		input logic cin, output core_uarch::word q, output logic cout, output logic vout);
		logic [32:0] sum;
		sum = {1'b0, x} + {1'b0, y} + cin;
		q = sum[31:0];
		cout = sum[32];
		vout = x[31] == y[31] && q[31] != x[31];
	endtask

	task automatic run_model();
		core_uarch::word insn, a, b, q, addr;
		logic sc, cout, vout, arith;
		int pc;
		pc = 0;
		for (int step = 0; step < 100000; step++) begin
			insn = ref_mem[pc];
			if (insn[27:25] == 3'b101 && insn[23:0] == 24'hfffffe)
				break;
			if (!cond_pass(insn[31:28]))
				pc++;
			else if (insn[27:26] == 2'b00) begin
				a = model_r[insn[19:16]];
				sc = c; // a rotated immediate keeps the carry.
				if (insn[25])
					b = ror32({24'd0, insn[7:0]}, 2 * insn[11:8]);
				else
					shift_operand(model_r[insn[3:0]], insn[6:5], insn[11:7], b, sc);
				arith = 1'b1;
				case (insn[24:21])
					4'h2, 4'ha: add_with_carry(a, ~b, 1'b1, q, cout, vout);
					4'h3: add_with_carry(~a, b, 1'b1, q, cout, vout);
					4'h4, 4'hb: add_with_carry(a, b, 1'b0, q, cout, vout);
					4'h5: add_with_carry(a, b, c, q, cout, vout);
					4'h6: add_with_carry(a, ~b, c, q, cout, vout);
					4'h7: add_with_carry(~a, b, c, q, cout, vout);
					default: arith = 1'b0;
				endcase
				case (insn[24:21])
					4'h0, 4'h8: q = a & b;
					4'h1, 4'h9: q = a ^ b;
					4'hc: q = a | b;
					4'hd: q = b;
					4'he: q = a & ~b;
					4'hf: q = ~b;
					default: ;
				endcase
				if (insn[24:23] != 2'b10)
					model_r[insn[15:12]] = q;
				if (insn[20]) begin
					n = q[31];
					z = q == 32'd0;
					c = arith ? cout : sc;
					if (arith)
						v = vout;
				end
				pc++;
			end else if (insn[27:26] == 2'b01) begin
				a = insn[19:16] == 4'd15 ? pc * 4 + 8 : model_r[insn[19:16]];
				addr = insn[23] ? a + insn[11:0] : a - insn[11:0];
				if (insn[20])
					model_r[insn[15:12]] = ref_mem[addr[11:2]];
				else begin
					ref_mem[addr[11:2]] = model_r[insn[15:12]];
					exp_addr.push_back(addr[31:2]);
					exp_data.push_back(model_r[insn[15:12]]);
				end
				pc++;
			end else begin
				if (insn[24])
					model_r[14] = (pc + 1) * 4;
				pc = pc + 2 + int'($signed(insn[23:0]));
			end
		end
	endtask

	// ##############################
	// Bus memory and checks.
	// ##############################

	task automatic check_write();
		assert (seen < exp_count) else begin
			other_errors++;
			$display("unexpected write at time %0t after all %0d modeled stores", $time, exp_count);
		end
		if (seen < exp_count) begin
			assert (bus_addr == exp_addr[seen] && bus_data_wr == exp_data[seen]) else begin
				mismatches++;
				$display("MISMATCH at time %0t: store %0d wrote %h to word %h, expected %h to word %h",
					$time, seen, bus_data_wr, bus_addr, exp_data[seen], exp_addr[seen]);
			end
			seen++;
		end
	endtask

	always begin
		@(posedge clk);
		#10;
		bus_ready = 1'b0;
		if (wait_left > 0) begin
			wait_left--;
			if (wait_left == 0) begin
				bus_ready = 1'b1;
				bus_data_rd = mem[req_addr];
			end
		end
		if (!rst && bus_start) begin
			req_addr = bus_addr[9:0];
			if (bus_write) begin
				check_write();
				mem[req_addr] = bus_data_wr;
			end
			wait_left = 1 + next_rand() % 4;
		end
	end

	task automatic finish_run(input bit timed_out);
		int failures;
		failures = mismatches + other_errors + u_arm810.bus_checks.failures;
		$display("errors: %0d mismatches, %0d other, %0d assertion failures, %0d of %0d stores",
			mismatches, other_errors, u_arm810.bus_checks.failures, seen, exp_count);
		if (!timed_out && failures == 0 && seen == exp_count)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		halt = 1'b0;
		bus_ready = 1'b0;
		bus_data_rd = '0;
		build_program();
		model_r = '{default: '0};
		{n, z, c, v} = 4'b0000;
		run_model();
		exp_count = exp_addr.size();
		repeat (4) @(posedge clk);
		#10 rst = 1'b0;
		repeat (300) @(posedge clk);
		#10 halt = 1'b1;
		for (int i = 0; i < 50 && !halted; i++) begin
			@(posedge clk);
			#10;
		end
		assert (halted) else begin
			other_errors++;
			$display("halted did not rise within 50 cycles of halt");
		end
		repeat (30) @(posedge clk);
		#10 halt = 1'b0;
		wait (seen >= exp_count);
		repeat (20) @(posedge clk); // any stray write shows up here.
		finish_run(1'b0);
	end

	initial begin
		@(negedge rst);
		repeat (8 * prog_len + 2000) @(posedge clk);
		$display("timeout: the program did not finish within %0d cycles", 8 * prog_len + 2000);
		finish_run(1'b1);
	end

endmodule

`default_nettype wire

/* core_alu.sv */
`default_nettype none

module core_alu #(
	parameter int W = 32
) (
	input  core_uarch::alu_op op,
	input  logic [W-1:0] a,
	input  logic [W-1:0] b,
	input  logic c_in,
	output logic [W-1:0] q,
	output core_uarch::psr_flags nzcv,
	output logic write
);

	logic [W-1:0] x, y;
	logic [W:0] sum;
	logic cin, arith, c, v;

	// every arithmetic op maps onto one adder with inverted inputs.
	always_comb begin
		x = a;
		y = b;
		cin = 1'b0;
		arith = 1'b1;
		unique case (op)
			core_uarch::OP_SUB, core_uarch::OP_CMP: begin
				y = ~b;
				cin = 1'b1;
			end
			core_uarch::OP_RSB: begin
				x = ~a;
				cin = 1'b1;
			end
			core_uarch::OP_ADC:
				cin = c_in;
			core_uarch::OP_SBC: begin
				y = ~b;
				cin = c_in;
			end
			core_uarch::OP_RSC: begin
				x = ~a;
				cin = c_in;
			end
			core_uarch::OP_ADD, core_uarch::OP_CMN:
				arith = 1'b1;
			default:
				arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, x} + {1'b0, y} + {{W{1'b0}}, cin};

	always_comb begin
		unique case (op)
			core_uarch::OP_AND, core_uarch::OP_TST: q = a & b;
			core_uarch::OP_EOR, core_uarch::OP_TEQ: q = a ^ b;
			core_uarch::OP_ORR: q = a | b;
			core_uarch::OP_MOV: q = b;
			core_uarch::OP_BIC: q = a & ~b;
			core_uarch::OP_MVN: q = ~b;
			default: q = sum[W-1:0];
		endcase
	end

	assign c = arith ? sum[W] : c_in;
	assign v = arith && x[W-1] == y[W-1] && sum[W-1] != x[W-1];
	assign nzcv = {q[W-1], ~|q, c, v};
	assign write = op[3:2] != 2'b10; // tst, teq, cmp and cmn only set flags.

endmodule

`default_nettype wire

/* core_bus_arbiter.sv */
`default_nettype none

module core_bus_arbiter (
	input  logic clk,
	input  logic rst,
	core_mem_if.server insn_port,
	core_mem_if.server data_port,
	output core_uarch::ptr bus_addr,
	output logic bus_start,
	output logic bus_write,
	input  logic bus_ready,
	input  core_uarch::word bus_data_rd,
	output core_uarch::word bus_data_wr
);

	logic insn_pend, data_pend, busy, owner_data;

	assign insn_port.ready = bus_ready && !owner_data;
	assign data_port.ready = bus_ready && owner_data;
	assign insn_port.data_rd = bus_data_rd;
	assign data_port.data_rd = bus_data_rd;

	always_ff @(posedge clk) begin
		bus_start <= 1'b0;

		if (rst) begin
			insn_pend <= 1'b0;
			data_pend <= 1'b0;
			busy <= 1'b0;
			owner_data <= 1'b0;
		end else begin
			if (insn_port.start)
				insn_pend <= 1'b1;
			if (data_port.start)
				data_pend <= 1'b1;
			if (bus_ready)
				busy <= 1'b0;

			// requesters hold their payload until ready, so it is sampled here.
			if (!busy && data_pend) begin
				bus_start <= 1'b1;
				bus_addr <= data_port.addr;
				bus_write <= data_port.write;
				bus_data_wr <= data_port.data_wr;
				busy <= 1'b1;
				owner_data <= 1'b1;
				data_pend <= 1'b0;
			end else if (!busy && insn_pend) begin
				bus_start <= 1'b1;
				bus_addr <= insn_port.addr;
				bus_write <= insn_port.write;
				bus_data_wr <= insn_port.data_wr;
				busy <= 1'b1;
				owner_data <= 1'b0;
				insn_pend <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* core_control.sv */
`default_nettype none

module core_control (
	input  logic clk,
	input  logic rst,
	input  logic halt,
	output logic halted,
	input  logic insn_valid,
	input  core_uarch::ptr insn_pc,
	output logic insn_pop,
	output logic flush,
	output core_uarch::ptr target,
	core_dec_if.sink dec,
	core_mem_if.requester mem,
	output core_uarch::reg_num ra,
	output core_uarch::reg_num rb,
	input  core_uarch::word rd_value_a,
	input  core_uarch::word rd_value_b,
	output core_uarch::reg_num wr_r,
	output logic wr_enable,
	output core_uarch::word wr_value,
	output core_uarch::alu_op alu_ctrl,
	output core_uarch::word alu_a,
	output core_uarch::word alu_b,
	input  core_uarch::word q_alu,
	input  core_uarch::psr_flags alu_flags,
	input  logic alu_write,
	output core_uarch::word sh_base,
	output core_uarch::shift_type sh_type,
	output logic [4:0] sh_amount,
	input  core_uarch::word q_shifter,
	input  logic c_shifter,
	output logic flags_c
);

	core_uarch::core_state state;
	core_uarch::psr_flags flags;
	core_uarch::reg_num load_rd;
	logic n, z, c, v, pass, exec, arith;

	assign {n, z, c, v} = flags;
	assign flags_c = c;
	assign halted = state == core_uarch::ST_HALTED;

	always_comb begin
		unique case (dec.cond)
			core_uarch::COND_EQ: pass = z;
			core_uarch::COND_NE: pass = !z;
			core_uarch::COND_CS: pass = c;
			core_uarch::COND_CC: pass = !c;
			core_uarch::COND_MI: pass = n;
			core_uarch::COND_PL: pass = !n;
			core_uarch::COND_VS: pass = v;
			core_uarch::COND_VC: pass = !v;
			core_uarch::COND_HI: pass = c && !z;
			core_uarch::COND_LS: pass = !c || z;
			core_uarch::COND_GE: pass = n == v;
			core_uarch::COND_LT: pass = n != v;
			core_uarch::COND_GT: pass = !z && n == v;
			core_uarch::COND_LE: pass = z || n != v;
			core_uarch::COND_AL: pass = 1'b1;
			default: pass = 1'b0;
		endcase
	end

	// ##############################
	// Issue and operand selection.
	// ##############################

	assign insn_pop = state == core_uarch::ST_RUN && insn_valid && !halt;
	assign exec = insn_pop && pass; // a failed condition still retires as a no-op.
	assign flush = exec && dec.cls == core_uarch::CLASS_BRANCH;
	assign target = insn_pc + 30'd2 + dec.branch_offset;

	assign arith = dec.op inside {core_uarch::OP_SUB, core_uarch::OP_RSB, core_uarch::OP_ADD,
		core_uarch::OP_ADC, core_uarch::OP_SBC, core_uarch::OP_RSC, core_uarch::OP_CMP,
		core_uarch::OP_CMN};

	assign ra = dec.rn;
	assign rb = dec.cls == core_uarch::CLASS_MEM ? dec.rd : dec.rm; // store data comes from rd.

	assign sh_base = rd_value_b;
	assign sh_type = dec.sh_type;
	assign sh_amount = dec.sh_amount;

	always_comb begin
		alu_a = rd_value_a;
		if (dec.cls == core_uarch::CLASS_MEM) begin
			alu_ctrl = dec.up ? core_uarch::OP_ADD : core_uarch::OP_SUB;
			alu_b = {20'd0, dec.offset};
		end else begin
			alu_ctrl = dec.op;
			alu_b = dec.imm_op ? dec.imm_value : q_shifter;
		end
	end

	always_comb begin
		wr_r = dec.rd;
		wr_value = q_alu;
		wr_enable = 1'b0;
		if (state == core_uarch::ST_MEM) begin
			wr_r = load_rd;
			wr_value = mem.data_rd;
			wr_enable = mem.ready && !mem.write;
		end else if (exec && dec.cls == core_uarch::CLASS_BRANCH) begin
			wr_r = 4'd14;
			wr_value = {insn_pc + 30'd1, 2'b00}; // byte address of the next instruction.
			wr_enable = dec.link;
		end else if (exec && dec.cls == core_uarch::CLASS_DP) begin
			wr_enable = alu_write;
		end
	end

	// ##############################
	// State and flags.
	// ##############################

	always_ff @(posedge clk) begin
		mem.start <= 1'b0;

		if (rst)
			state <= core_uarch::ST_RUN;
		else begin
			unique case (state)
				core_uarch::ST_RUN:
					if (halt)
						state <= core_uarch::ST_HALTED;
					else if (exec && dec.cls == core_uarch::CLASS_MEM) begin
						mem.start <= 1'b1;
						mem.addr <= q_alu[31:2];
						mem.write <= !dec.load;
						mem.data_wr <= rd_value_b;
						load_rd <= dec.rd;
						state <= core_uarch::ST_MEM;
					end
				core_uarch::ST_MEM:
					if (mem.ready)
						state <= halt ? core_uarch::ST_HALTED : core_uarch::ST_RUN;
				core_uarch::ST_HALTED:
					if (!halt)
						state <= core_uarch::ST_RUN;
				default:
					state <= core_uarch::ST_RUN;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			flags <= '0;
		else if (exec && dec.cls == core_uarch::CLASS_DP && dec.set_flags) begin
			flags[3:2] <= alu_flags[3:2];
			if (arith)
				flags[1:0] <= alu_flags[1:0];
			else if (!dec.imm_op)
				flags[1] <= c_shifter; // logical ops keep v.
		end
	end

endmodule

`default_nettype wire

/* core_decode.sv */
`default_nettype none

module core_decode (
	input core_uarch::word insn,
	core_dec_if.source dec
);

	logic is_dp, is_mem, is_branch;
	logic [63:0] imm_pair;

	// only immediate shifts; multiply, halfword and PSR transfers fall out here.
	assign is_dp = insn[27:26] == 2'b00 && (insn[25] || !insn[4])
		&& !(insn[24:23] == 2'b10 && !insn[20]) && insn[15:12] != 4'd15;

	// word transfer, immediate offset, pre-indexed, no writeback.
	assign is_mem = insn[27:25] == 3'b010 && insn[24] && !insn[22] && !insn[21]
		&& !(insn[20] && insn[15:12] == 4'd15);

	assign is_branch = insn[27:25] == 3'b101;

	always_comb begin
		if (insn[31:28] == 4'hf)
			dec.cls = core_uarch::CLASS_UNDEF;
		else if (is_dp)
			dec.cls = core_uarch::CLASS_DP;
		else if (is_mem)
			dec.cls = core_uarch::CLASS_MEM;
		else if (is_branch)
			dec.cls = core_uarch::CLASS_BRANCH;
		else
			dec.cls = core_uarch::CLASS_UNDEF;
	end

	assign dec.cond = insn[31:28];
	assign dec.op = insn[24:21];
	assign dec.set_flags = insn[20];
	assign dec.rn = insn[19:16];
	assign dec.rd = insn[15:12];
	assign dec.rm = insn[3:0];

	assign imm_pair = {2{24'd0, insn[7:0]}} >> {insn[11:8], 1'b0};

	assign dec.imm_op = insn[25];
	assign dec.imm_value = imm_pair[31:0]; // rotate right by twice the field.
	assign dec.sh_type = insn[6:5];
	assign dec.sh_amount = insn[11:7];

	assign dec.load = insn[20];
	assign dec.up = insn[23];
	assign dec.offset = insn[11:0];

	assign dec.link = insn[24];
	assign dec.branch_offset = {{6{insn[23]}}, insn[23:0]};

endmodule

`default_nettype wire

/* core_fetch.sv */
`default_nettype none

module core_fetch #(
	parameter int PREFETCH_ORDER = 1
) (
	input  logic clk,
	input  logic rst,
	core_mem_if.requester mem,
	output logic insn_valid,
	output core_uarch::word insn,
	output core_uarch::ptr insn_pc,
	input  logic insn_pop,
	input  logic flush,
	input  core_uarch::ptr target
);

	core_uarch::word insn_q[2 ** PREFETCH_ORDER];
	core_uarch::ptr pc_q[2 ** PREFETCH_ORDER];
	core_uarch::ptr fetch_ptr;
	logic [PREFETCH_ORDER-1:0] rd_idx, wr_idx;
	logic [PREFETCH_ORDER:0] count; // msb set means the queue is full.
	logic pending, discard, push;

	assign push = mem.ready && !discard && !flush;

	assign insn_valid = |count;
	assign insn = insn_q[rd_idx];
	assign insn_pc = pc_q[rd_idx];

	assign mem.write = 1'b0; // the fetch port only reads.
	assign mem.data_wr = '0;

	always_ff @(posedge clk) begin
		if (push) begin
			insn_q[wr_idx] <= mem.data_rd;
			pc_q[wr_idx] <= mem.addr; // addr is held while the fetch is outstanding.
		end
	end

	always_ff @(posedge clk) begin
		mem.start <= 1'b0;

		if (rst) begin
			fetch_ptr <= core_uarch::RESET_PC;
			rd_idx <= '0;
			wr_idx <= '0;
			count <= '0;
			pending <= 1'b0;
			discard <= 1'b0;
		end else begin
			if (mem.ready) begin
				pending <= 1'b0;
				discard <= 1'b0;
			end

			if (flush) begin
				fetch_ptr <= target;
				rd_idx <= '0;
				wr_idx <= '0;
				count <= '0;
				discard <= pending && !mem.ready; // the old response is dropped on arrival.
			end else begin
				if (push)
					wr_idx <= wr_idx + 1'b1;

				if (insn_pop)
					rd_idx <= rd_idx + 1'b1;

				if (push && !insn_pop)
					count <= count + 1'b1;
				else if (!push && insn_pop)
					count <= count - 1'b1;

				if (!pending && !count[PREFETCH_ORDER]) begin
					mem.start <= 1'b1;
					mem.addr <= fetch_ptr;
					fetch_ptr <= fetch_ptr + 1'b1;
					pending <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* core_if.sv */
`default_nettype none

interface core_mem_if;
	core_uarch::ptr addr;
	logic start, write, ready;
	core_uarch::word data_rd, data_wr;

	modport requester(output addr, start, write, data_wr, input ready, data_rd);
	modport server(input addr, start, write, data_wr, output ready, data_rd);
endinterface

interface core_dec_if;
	core_uarch::insn_class cls;
	core_uarch::cond_code cond;
	core_uarch::alu_op op;
	logic set_flags, imm_op, load, up, link;
	core_uarch::reg_num rd, rn, rm;
	core_uarch::word imm_value;
	core_uarch::shift_type sh_type;
	logic [4:0] sh_amount;
	logic [11:0] offset;
	core_uarch::ptr branch_offset;

	modport source(output cls, cond, op, set_flags, rd, rn, rm, imm_op, imm_value,
		sh_type, sh_amount, load, up, offset, link, branch_offset);
	modport sink(input cls, cond, op, set_flags, rd, rn, rm, imm_op, imm_value,
		sh_type, sh_amount, load, up, offset, link, branch_offset);
endinterface

`default_nettype wire

/* core_regs.sv */
`default_nettype none

module core_regs (
	input  logic clk,
	input  logic rst,
	input  core_uarch::reg_num rd_r_a,
	input  core_uarch::reg_num rd_r_b,
	output core_uarch::word rd_value_a,
	output core_uarch::word rd_value_b,
	input  core_uarch::reg_num wr_r,
	input  logic wr_enable,
	input  core_uarch::word wr_value,
	input  core_uarch::word pc_visible
);

	core_uarch::word gpr[15]; // r0 to r14; r15 is the fetch pc.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 15; i++)
				gpr[i] <= '0;
		end else if (wr_enable && wr_r != 4'd15)
			gpr[wr_r] <= wr_value;
	end

	assign rd_value_a = rd_r_a == 4'd15 ? pc_visible : gpr[rd_r_a];
	assign rd_value_b = rd_r_b == 4'd15 ? pc_visible : gpr[rd_r_b];

endmodule

`default_nettype wire

/* core_shifter.sv */
`default_nettype none

module core_shifter #(
	parameter int W = 32
) (
	input  logic [W-1:0] base,
	input  core_uarch::shift_type sh_type,
	input  logic [4:0] amount,
	input  logic c_in,
	output logic [W-1:0] q,
	output logic c
);

	logic [2*W-1:0] rot;

	assign rot = {base, base} >> amount;

	always_comb begin
		q = base;
		c = c_in;
		unique case (sh_type)
			core_uarch::SH_LSL:
				{c, q} = {c_in, base} << amount; // lsl #0 leaves carry alone.
			core_uarch::SH_LSR:
				if (amount == 5'd0) begin
					q = '0; // encodes lsr #32.
					c = base[W-1];
				end else
					{q, c} = {base, 1'b0} >> amount;
			core_uarch::SH_ASR:
				if (amount == 5'd0) begin
					q = {W{base[W-1]}};
					c = base[W-1];
				end else
					{q, c} = $signed({base, 1'b0}) >>> amount;
			core_uarch::SH_ROR:
				if (amount == 5'd0) begin
					q = {c_in, base[W-1:1]}; // rrx.
					c = base[0];
				end else begin
					q = rot[W-1:0];
					c = rot[W-1];
				end
		endcase
	end

endmodule

`default_nettype wire

/* uarch.sv */
`default_nettype none

package core_uarch;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr; // word address, byte address >> 2.
	typedef logic [3:0] reg_num;
	typedef logic [3:0] psr_flags; // n, z, c, v from msb down.

	typedef logic [3:0] alu_op;
	localparam alu_op OP_AND = 4'h0;
	localparam alu_op OP_EOR = 4'h1;
	localparam alu_op OP_SUB = 4'h2;
	localparam alu_op OP_RSB = 4'h3;
	localparam alu_op OP_ADD = 4'h4;
	localparam alu_op OP_ADC = 4'h5;
	localparam alu_op OP_SBC = 4'h6;
	localparam alu_op OP_RSC = 4'h7;
	localparam alu_op OP_TST = 4'h8;
	localparam alu_op OP_TEQ = 4'h9;
	localparam alu_op OP_CMP = 4'ha;
	localparam alu_op OP_CMN = 4'hb;
	localparam alu_op OP_ORR = 4'hc;
	localparam alu_op OP_MOV = 4'hd;
	localparam alu_op OP_BIC = 4'he;
	localparam alu_op OP_MVN = 4'hf;

	typedef logic [1:0] shift_type;
	localparam shift_type SH_LSL = 2'd0;
	localparam shift_type SH_LSR = 2'd1;
	localparam shift_type SH_ASR = 2'd2;
	localparam shift_type SH_ROR = 2'd3;

	typedef logic [3:0] cond_code;
	localparam cond_code COND_EQ = 4'h0;
	localparam cond_code COND_NE = 4'h1;
	localparam cond_code COND_CS = 4'h2;
	localparam cond_code COND_CC = 4'h3;
	localparam cond_code COND_MI = 4'h4;
	localparam cond_code COND_PL = 4'h5;
	localparam cond_code COND_VS = 4'h6;
	localparam cond_code COND_VC = 4'h7;
	localparam cond_code COND_HI = 4'h8;
	localparam cond_code COND_LS = 4'h9;
	localparam cond_code COND_GE = 4'ha;
	localparam cond_code COND_LT = 4'hb;
	localparam cond_code COND_GT = 4'hc;
	localparam cond_code COND_LE = 4'hd;
	localparam cond_code COND_AL = 4'he;

	typedef logic [1:0] insn_class;
	localparam insn_class CLASS_DP = 2'd0;
	localparam insn_class CLASS_MEM = 2'd1;
	localparam insn_class CLASS_BRANCH = 2'd2;
	localparam insn_class CLASS_UNDEF = 2'd3; // executes as a no-op.

	typedef enum logic [1:0] {
		ST_RUN,
		ST_MEM,
		ST_HALTED
	} core_state;

	localparam ptr RESET_PC = '0;

endpackage

`default_nettype wire
